/* logic/exu_macros.svh */
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// full datapath width, the core is RV64 only.
`define EXU_XLEN 64

// width of the *W instructions, results are sign-extended from here.
`define EXU_WLEN 32

// the iteration counter must hold the largest iteration count.
`define EXU_CNT_W 7

`endif

/* logic/exu_pkg.sv */
`include "exu_macros.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0] exu_word_t;

    typedef enum logic [1:0] {
        CLS_ALU = 2'd0,
        CLS_MUL = 2'd1,
        CLS_DIV = 2'd2
    } exu_cls_e;

    // subtract also needs add_sub set; the compares use the adder on their own.
    typedef struct packed {
        logic add_sub;
        logic sub;
        logic slt;
        logic sltu;
        logic and_op;
        logic or_op;
        logic xor_op;
        logic sll;
        logic srl;
        logic sra;
    } alu_sel_t;

    typedef struct packed {
        logic [1:0] sgn;     // bit 1 is operand 1 signed, bit 0 is operand 2 signed.
        logic       pick_lo; // low product word, or the quotient for a divide.
        logic [6:0] pad;
    } md_ctl_t;

    // the same select field, read as ALU selects or as muldiv control by class.
    typedef union packed {
        alu_sel_t alu;
        md_ctl_t  md;
    } exu_op_u;

    typedef struct packed {
        exu_cls_e cls;
        logic     word;
        exu_op_u  sel;
    } exu_op_t;

    typedef struct packed {
        exu_op_t   op;
        exu_word_t src1;
        exu_word_t src2;
    } exu_req_t;

    function automatic exu_word_t sext_word(input exu_word_t v);
        return {{(`EXU_XLEN-`EXU_WLEN){v[`EXU_WLEN-1]}}, v[`EXU_WLEN-1:0]};
    endfunction

    // sign of an operand as the operation sees it.
    function automatic logic is_neg(input exu_word_t v, input logic sgn, input logic word);
        return sgn & (word ? v[`EXU_WLEN-1] : v[`EXU_XLEN-1]);
    endfunction

    // unsigned magnitude; the most negative value maps to its positive power of two.
    function automatic exu_word_t magnitude(input exu_word_t v, input logic sgn,
                                            input logic word);
        exu_word_t ext;
        ext = v;
        if (word) begin
            ext = sgn ? sext_word(v) : {{(`EXU_XLEN-`EXU_WLEN){1'b0}}, v[`EXU_WLEN-1:0]};
        end
        return is_neg(v, sgn, word) ? -ext : ext;
    endfunction

endpackage

/* logic/exu_alu.sv */
`include "exu_macros.svh"

module exu_alu import exu_pkg::*; (
    input  logic      word,
    input  exu_word_t a,
    input  exu_word_t b,
    input  alu_sel_t  sel,
    output exu_word_t result
);

    logic               subtract;
    logic [`EXU_XLEN:0] sum;     // carry out sits in the top bit.
    logic               less;
    logic [5:0]         shamt;
    exu_word_t          sh_in;
    logic               fill;
    logic [`EXU_XLEN:0] sh_wide;
    exu_word_t          sh_out;
    exu_word_t          raw;

    function automatic exu_word_t bit_rev(input exu_word_t v);
        exu_word_t r;
        for (int i = 0; i < `EXU_XLEN; i++) begin
            r[i] = v[`EXU_XLEN-1-i];
        end
        return r;
    endfunction

    // one adder for add, sub and both compares.
    assign subtract = sel.sub | sel.slt | sel.sltu;
    assign sum = {1'b0, a} + {1'b0, subtract ? ~b : b} + {{`EXU_XLEN{1'b0}}, subtract};

    // unsigned less is a missing carry, signed less looks at the operand signs first.
    assign less = sel.sltu ? ~sum[`EXU_XLEN] :
                  (a[`EXU_XLEN-1] != b[`EXU_XLEN-1]) ? a[`EXU_XLEN-1] : sum[`EXU_XLEN-1];

    assign shamt = word ? {1'b0, b[4:0]} : b[5:0];

    // left shifts go through the right shifter on a reversed operand.
    always_comb begin
        if (sel.sll) begin
            sh_in = bit_rev(a);
        end else if (word) begin
            sh_in = sel.sra ? sext_word(a) : {{(`EXU_XLEN-`EXU_WLEN){1'b0}}, a[`EXU_WLEN-1:0]};
        end else begin
            sh_in = a;
        end
    end

    assign fill    = sel.sra & sh_in[`EXU_XLEN-1];
    assign sh_wide = $signed({fill, sh_in}) >>> shamt;
    assign sh_out  = sel.sll ? bit_rev(sh_wide[`EXU_XLEN-1:0]) : sh_wide[`EXU_XLEN-1:0];

    always_comb begin
        raw = '0;
        if (sel.add_sub) begin
            raw = sum[`EXU_XLEN-1:0];
        end else if (sel.slt | sel.sltu) begin
            raw = {{(`EXU_XLEN-1){1'b0}}, less};
        end else if (sel.and_op) begin
            raw = a & b;
        end else if (sel.or_op) begin
            raw = a | b;
        end else if (sel.xor_op) begin
            raw = a ^ b;
        end else if (sel.sll | sel.srl | sel.sra) begin
            raw = sh_out;
        end
    end

    assign result = word ? sext_word(raw) : raw; // word forms extend bit 31.

endmodule

/* logic/exu_mul.sv */
`include "exu_macros.svh"

module exu_mul import exu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       flush,
    input  logic       start,
    input  logic       word,
    input  logic [1:0] sgn,
    input  exu_word_t  multiplicand,
    input  exu_word_t  multiplier,
    output logic       done,
    output exu_word_t  result_hi,
    output exu_word_t  result_lo
);

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_SETUP,
        MUL_RUN,
        MUL_DONE
    } mul_state_e;

    mul_state_e             state_q;
    logic [`EXU_CNT_W-1:0]  cnt_q;
    logic                   word_q;
    logic [1:0]             sgn_q;
    logic                   neg_q;     // product sign.
    exu_word_t              mcand_q;
    logic [2*`EXU_XLEN-1:0] acc_q;     // partial product above, multiplier bits below.
    logic                   last_iter;
    logic [`EXU_XLEN:0]     part_sum;
    logic [2*`EXU_XLEN-1:0] prod_mag;
    logic [2*`EXU_XLEN-1:0] prod;

    assign last_iter = cnt_q == (word_q ? `EXU_CNT_W'(`EXU_WLEN-1) : `EXU_CNT_W'(`EXU_XLEN-1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= MUL_IDLE;
            cnt_q   <= '0;
            word_q  <= 1'b0;
            sgn_q   <= '0;
            neg_q   <= 1'b0;
        end else if (flush) begin
            state_q <= MUL_IDLE; // an aborted product is simply dropped.
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (start) begin
                        state_q <= MUL_SETUP;
                        word_q  <= word;
                        sgn_q   <= sgn;
                    end
                end
                MUL_SETUP: begin
                    state_q <= MUL_RUN;
                    cnt_q   <= '0;
                    neg_q   <= is_neg(mcand_q, sgn_q[1], word_q) ^
                               is_neg(acc_q[`EXU_XLEN-1:0], sgn_q[0], word_q);
                end
                MUL_RUN: begin
                    cnt_q <= cnt_q + `EXU_CNT_W'(1);
                    if (last_iter) begin
                        state_q <= MUL_DONE;
                    end
                end
                default: state_q <= MUL_IDLE; // done lasts one cycle.
            endcase
        end
    end

    // add the multiplicand into the upper half when the current multiplier bit is set.
    assign part_sum = {1'b0, acc_q[2*`EXU_XLEN-1:`EXU_XLEN]} +
                      (acc_q[0] ? {1'b0, mcand_q} : {(`EXU_XLEN+1){1'b0}});

    always_ff @(posedge clk) begin
        case (state_q)
            MUL_IDLE: begin
                mcand_q <= multiplicand;
                acc_q   <= {{`EXU_XLEN{1'b0}}, multiplier};
            end
            MUL_SETUP: begin
                mcand_q                <= magnitude(mcand_q, sgn_q[1], word_q);
                acc_q[`EXU_XLEN-1:0]   <= magnitude(acc_q[`EXU_XLEN-1:0], sgn_q[0], word_q);
            end
            MUL_RUN: acc_q <= {part_sum, acc_q[`EXU_XLEN-1:1]};
            default: ;
        endcase
    end

    // after 32 steps the word product has moved only halfway down the accumulator.
    assign prod_mag = word_q ? {{`EXU_XLEN{1'b0}}, acc_q[`EXU_XLEN+`EXU_WLEN-1:`EXU_WLEN]}
                             : acc_q;
    assign prod = neg_q ? -prod_mag : prod_mag;

    assign done      = state_q == MUL_DONE;
    assign result_lo = word_q ? sext_word(prod[`EXU_XLEN-1:0]) : prod[`EXU_XLEN-1:0];
    assign result_hi = word_q ? sext_word(prod[`EXU_XLEN-1:0]) : prod[2*`EXU_XLEN-1:`EXU_XLEN];

endmodule

/* logic/exu_div.sv */
`include "exu_macros.svh"

module exu_div import exu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       flush,
    input  logic       start,
    input  logic       word,
    input  logic [1:0] sgn,
    input  exu_word_t  dividend,
    input  exu_word_t  divisor,
    output logic       done,
    output exu_word_t  quotient,
    output exu_word_t  remainder
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e            state_q;
    logic [`EXU_CNT_W-1:0] cnt_q;
    logic                  word_q;
    logic                  q_neg_q;
    logic                  r_neg_q;
    exu_word_t             quo_q;   // dividend bits shift out the top, quotient bits in below.
    exu_word_t             rem_q;
    exu_word_t             dvs_q;
    logic                  a_neg;
    logic                  b_neg;
    logic                  div_zero;
    logic                  overflow;
    logic                  min_val;
    logic                  neg_one;
    exu_word_t             a_mag;
    logic [`EXU_XLEN:0]    shifted;
    logic [`EXU_XLEN+1:0]  diff;
    logic                  ge;
    logic                  last_iter;
    exu_word_t             q_fix;
    exu_word_t             r_fix;

    assign a_neg = is_neg(dividend, sgn[1], word);
    assign b_neg = is_neg(divisor, sgn[0], word);
    assign a_mag = magnitude(dividend, sgn[1], word);

    // the special cases are decided from the operands as they are accepted.
    assign div_zero = word ? (divisor[`EXU_WLEN-1:0] == '0) : (divisor == '0);
    assign min_val  = word ? (dividend[`EXU_WLEN-1:0] == {1'b1, {(`EXU_WLEN-1){1'b0}}})
                           : (dividend == {1'b1, {(`EXU_XLEN-1){1'b0}}});
    assign neg_one  = word ? (&divisor[`EXU_WLEN-1:0]) : (&divisor);
    assign overflow = (&sgn) & min_val & neg_one;

    assign last_iter = cnt_q == (word_q ? `EXU_CNT_W'(`EXU_WLEN-1) : `EXU_CNT_W'(`EXU_XLEN-1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
            word_q  <= 1'b0;
            q_neg_q <= 1'b0;
            r_neg_q <= 1'b0;
        end else if (flush) begin
            state_q <= DIV_IDLE;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start) begin
                        word_q <= word;
                        cnt_q  <= '0;
                        if (div_zero | overflow) begin
                            state_q <= DIV_DONE; // results are loaded ready to go.
                            q_neg_q <= 1'b0;
                            r_neg_q <= 1'b0;
                        end else begin
                            state_q <= DIV_RUN;
                            q_neg_q <= a_neg ^ b_neg;
                            r_neg_q <= a_neg; // remainder follows the dividend.
                        end
                    end
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + `EXU_CNT_W'(1);
                    if (last_iter) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    // one restoring step: shift in the next dividend bit and try to subtract.
    assign shifted = {rem_q, quo_q[`EXU_XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvs_q};
    assign ge      = ~diff[`EXU_XLEN+1];

    always_ff @(posedge clk) begin
        case (state_q)
            DIV_IDLE: begin
                dvs_q <= magnitude(divisor, sgn[0], word);
                if (div_zero) begin
                    quo_q <= '1;
                    rem_q <= dividend;
                end else if (overflow) begin
                    quo_q <= dividend;
                    rem_q <= '0;
                end else begin
                    // a word dividend starts at the top so the step logic stays the same.
                    quo_q <= word ? {a_mag[`EXU_WLEN-1:0], {(`EXU_XLEN-`EXU_WLEN){1'b0}}} : a_mag;
                    rem_q <= '0;
                end
            end
            DIV_RUN: begin
                rem_q <= ge ? diff[`EXU_XLEN-1:0] : shifted[`EXU_XLEN-1:0];
                quo_q <= {quo_q[`EXU_XLEN-2:0], ge};
            end
            default: ;
        endcase
    end

    assign q_fix = q_neg_q ? -quo_q : quo_q;
    assign r_fix = r_neg_q ? -rem_q : rem_q;

    assign done      = state_q == DIV_DONE;
    assign quotient  = word_q ? sext_word(q_fix) : q_fix;
    assign remainder = word_q ? sext_word(r_fix) : r_fix;

endmodule

/* logic/exu.sv */
module exu import exu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    input  logic      in_valid,
    input  exu_req_t  req,
    output logic      out_valid,
    output exu_word_t result
);

    md_ctl_t   md;
    logic      mul_start;
    logic      div_start;
    logic      mul_done;
    logic      div_done;
    exu_word_t alu_result;
    exu_word_t mul_hi;
    exu_word_t mul_lo;
    exu_word_t quotient;
    exu_word_t remainder;

    assign md        = req.op.sel.md; // muldiv view of the select field.
    assign mul_start = in_valid & (req.op.cls == CLS_MUL);
    assign div_start = in_valid & (req.op.cls == CLS_DIV);

    exu_alu u_exu_alu (
        .word   (req.op.word),
        .a      (req.src1),
        .b      (req.src2),
        .sel    (req.op.sel.alu),
        .result (alu_result)
    );

    exu_mul u_exu_mul (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .start        (mul_start),
        .word         (req.op.word),
        .sgn          (md.sgn),
        .multiplicand (req.src1),
        .multiplier   (req.src2),
        .done         (mul_done),
        .result_hi    (mul_hi),
        .result_lo    (mul_lo)
    );

    exu_div u_exu_div (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .start     (div_start),
        .word      (req.op.word),
        .sgn       (md.sgn),
        .dividend  (req.src1),
        .divisor   (req.src2),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    // the ALU answers at once, the iterative units answer with their done strobe.
    always_comb begin
        case (req.op.cls)
            CLS_MUL: begin
                result    = md.pick_lo ? mul_lo : mul_hi;
                out_valid = mul_done;
            end
            CLS_DIV: begin
                result    = md.pick_lo ? quotient : remainder;
                out_valid = div_done;
            end
            default: begin
                result    = alu_result;
                out_valid = in_valid;
            end
        endcase
    end

endmodule

/* bench/exu_props.sv */
module exu_props import exu_pkg::*; (
    input logic     clk,
    input logic     arst_n,
    input logic     in_valid,
    input logic     out_valid,
    input logic     mul_done,
    input logic     div_done,
    input exu_req_t req
);

    timeunit 1ns;
    timeprecision 1ps;

    // a result only ever answers a held request.
    a_valid_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        !in_valid |-> !out_valid)
        else $error("out_valid is high while in_valid is low");

    // an ALU op answers at once and no iterative unit finishes behind it.
    a_alu_same_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        (in_valid && req.op.cls == CLS_ALU) |-> (out_valid && !mul_done && !div_done))
        else $error("an ALU request did not answer cleanly in its own cycle");

    a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(out_valid))
        else $error("out_valid is unknown");

    // done is a single cycle strobe. A following ALU op may answer at once.
    a_done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && req.op.cls != CLS_ALU) |=> (!out_valid || req.op.cls == CLS_ALU))
        else $error("out_valid of a multi-cycle op lasted more than one cycle");

endmodule

bind exu exu_props u_exu_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .mul_done  (mul_done),
    .div_done  (div_done),
    .req       (req)
);

/* bench/exu_tb.sv */
module exu_tb import exu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CYCLES_PER_OP = 140;
    localparam int    FLUSH_WATCH   = 70;   // cycles that must stay quiet after a flush.
    localparam string TRACE_FILE    = "bench/exu_trace.txt";

    logic      clk;
    logic      arst_n;
    logic      flush;
    logic      in_valid;
    exu_req_t  req;
    logic      out_valid;
    exu_word_t result;

    // one entry per trace line.
    string     names[$];
    exu_op_t   ops[$];
    exu_word_t src1s[$];
    exu_word_t src2s[$];
    exu_word_t expects[$];
    int        flush_afters[$];

    int        seed;
    int        cycle_count;
    int        cycle_limit;

    exu DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .result    (result)
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            report_failure($sformatf("timeout, the run took more than %0d cycles", cycle_limit));
        end
    end

    task automatic check_result(input string name, input exu_word_t expected,
                                input exu_word_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_idle(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error %s: expected out_valid %b, actual %b",
                                     name, expected, actual));
        end
    endtask

    task automatic read_trace();
        int         fd;
        int         n;
        int         cls;
        int         word;
        int         flush_after;
        string      line;
        string      name;
        logic [9:0] sel;
        exu_word_t  a;
        exu_word_t  b;
        exu_word_t  expected;
        exu_op_t    op;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            report_failure("the trace file could not be opened");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue; // blank lines and column notes.
            end
            n = $sscanf(line, "%s %d %d %h %h %h %h %d", name, cls, word, sel, a, b,
                        expected, flush_after);
            if (n != 8) begin
                report_failure({"a trace line could not be parsed: ", line});
            end
            op.cls  = exu_cls_e'(cls[1:0]);
            op.word = word[0];
            op.sel  = exu_op_u'(sel);
            names.push_back(name);
            ops.push_back(op);
            src1s.push_back(a);
            src2s.push_back(b);
            expects.push_back(expected);
            flush_afters.push_back(flush_after);
        end
        $fclose(fd);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic issue_op(input int idx);
        @(negedge clk);
        req.op   = ops[idx];
        req.src1 = src1s[idx];
        req.src2 = src2s[idx];
        in_valid = 1'b1;
    endtask

    // the request is held until out_valid shows at a rising edge.
    task automatic await_result(input int idx);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited == 1 && ops[idx].cls != CLS_ALU) begin
                check_idle(names[idx], 1'b0, out_valid); // accept edge, nothing done yet.
            end
            if (waited > CYCLES_PER_OP) begin
                report_failure($sformatf("%s never raised out_valid", names[idx]));
            end
        end while (!out_valid);
        check_result(names[idx], expects[idx], result);
    endtask

    task automatic flush_op(input int idx);
        repeat (flush_afters[idx]) begin
            @(posedge clk);
            check_idle(names[idx], 1'b0, out_valid);
        end
        @(negedge clk);
        flush    = 1'b1;
        in_valid = 1'b0;
        @(negedge clk);
        flush = 1'b0;
        repeat (FLUSH_WATCH) begin
            @(posedge clk);
            check_idle(names[idx], 1'b0, out_valid);
        end
    endtask

    initial begin
        int       gap;
        exu_cls_e prev_cls;
        logic     prev_flushed;
        seed         = 99335;
        clk          = 1'b0;
        arst_n       = 1'b0;
        flush        = 1'b0;
        in_valid     = 1'b0;
        req          = '0;
        cycle_count  = 0;
        cycle_limit  = 0;
        prev_cls     = CLS_ALU;
        prev_flushed = 1'b0;
        read_trace();
        cycle_limit = names.size() * CYCLES_PER_OP;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < names.size(); i++) begin
            gap = $random(seed) & 3;
            // same class multi-cycle ops follow each other with no idle gap.
            if (ops[i].cls != CLS_ALU && ops[i].cls == prev_cls && !prev_flushed) begin
                gap = 0;
            end
            idle_cycles(gap);
            issue_op(i);
            if (flush_afters[i] > 0) begin
                flush_op(i);
            end else begin
                await_result(i);
            end
            prev_cls     = ops[i].cls;
            prev_flushed = flush_afters[i] > 0;
        end
        idle_cycles(2);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* bench/exu_trace.txt */
# name cls word sel src1 src2 expected flush_after
# cls 0 alu, 1 mul, 2 div; sel, sources and expected in hex; flush_after in cycles, 0 none
add_wrap     0 0 200 7fffffffffffffff 0000000000000001 8000000000000000 0
sub_neg      0 0 300 0000000000000005 0000000000000008 fffffffffffffffd 0
slt_neg      0 0 080 fffffffffffffffe 0000000000000001 0000000000000001 0
sltu_big     0 0 040 fffffffffffffffe 0000000000000001 0000000000000000 0
and_bits     0 0 020 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000 0
or_bits      0 0 010 f0f0f0f0f0f0f0f0 0f000f000f000f00 fff0fff0fff0fff0 0
xor_bits     0 0 008 aaaaaaaaaaaaaaaa ffffffffffffffff 5555555555555555 0
sll_max      0 0 004 0000000000000001 000000000000003f 8000000000000000 0
srl          0 0 002 8000000000000000 0000000000000004 0800000000000000 0
sra          0 0 001 8000000000000000 0000000000000004 f800000000000000 0
addw_wrap    0 1 200 000000007fffffff 0000000000000001 ffffffff80000000 0
subw_neg     0 1 300 0000000000000000 0000000000000001 ffffffffffffffff 0
sllw_mask    0 1 004 0000000000000001 000000000000003f ffffffff80000000 0
srlw         0 1 002 ffffffff80000000 0000000000000004 0000000008000000 0
sraw         0 1 001 0000000080000000 0000000000000004 fffffffff8000000 0
mul_neg      1 0 380 fffffffffffffffd 0000000000000007 ffffffffffffffeb 0
mulh_neg     1 0 300 fffffffffffffffd 0000000000000007 ffffffffffffffff 0
mulhsu       1 0 200 4000000000000000 ffffffffffffffff 3fffffffffffffff 0
mulhu        1 0 000 ffffffffffffffff ffffffffffffffff fffffffffffffffe 0
mulw         1 1 380 abcdef0010000000 0000000000000009 ffffffff90000000 0
mul_flush    1 0 380 0000000000000003 0000000000000005 0000000000000000 5
mul_resume   1 0 380 0000000000000006 0000000000000007 000000000000002a 0
div_neg      2 0 380 ffffffffffffff9c 0000000000000007 fffffffffffffff2 0
rem_neg      2 0 300 ffffffffffffff9c 0000000000000007 fffffffffffffffe 0
divu         2 0 080 8000000000000000 0000000000000010 0800000000000000 0
remu         2 0 000 ffffffffffffffff 0000000000000010 000000000000000f 0
divw_neg     2 1 380 00000000fffffff9 0000000000000002 fffffffffffffffd 0
remw_neg     2 1 300 00000000fffffff9 0000000000000002 ffffffffffffffff 0
divuw        2 1 080 00000000fffffff9 0000000000000002 000000007ffffffc 0
div_zero     2 0 380 0000000000001234 0000000000000000 ffffffffffffffff 0
rem_zero     2 0 300 0000000000001234 0000000000000000 0000000000001234 0
div_ovf      2 0 380 8000000000000000 ffffffffffffffff 8000000000000000 0
rem_ovf      2 0 300 8000000000000000 ffffffffffffffff 0000000000000000 0
divw_ovf     2 1 380 0000000080000000 00000000ffffffff ffffffff80000000 0
div_flush    2 0 080 0000000000000064 0000000000000003 0000000000000000 4
div_resume   2 0 080 0000000000000064 0000000000000003 0000000000000021 0
add_last     0 0 200 fffffffffffffff0 0000000000000010 0000000000000000 0

/* verilog.f */
+incdir+logic
logic/exu_pkg.sv
logic/exu_alu.sv
logic/exu_mul.sv
logic/exu_div.sv
logic/exu.sv
bench/exu_props.sv
bench/exu_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = exu_tb
FILELIST = verilog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
